// ==== flist.f ====
hdl/sd_spi_pkg.sv
hdl/sd_spi_reg_front.sv
hdl/sd_spi_cmd_seq.sv
hdl/sd_spi_shifter.sv
hdl/sd_spi_host.sv
test/sd_spi_host_assertions.sv
test/sd_spi_host_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the SD SPI host testbench
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    -f flist.f \
    --top-module sd_spi_host_tb \
    -o sd_spi_host_sim &&
./obj_dir/sd_spi_host_sim ||
{ echo "sd_spi_host simulation failed" >&2; exit 1; }

// ==== test/sd_spi_host_tb.sv ====
/*
 * Testbench for the SD card SPI host
 * Applies a table of bus operations, models the card on MISO and
 * checks MOSI commands, SCLK pulse counts and read data
 */
`timescale 1ns/1ps

module sd_spi_host_tb;

    localparam int DIV_TB   = 1;       // Divider written by the first row
    localparam int STREAM_W = 160;
    localparam int NUM_ROWS = 10;

    // Expected commands, start bits in the index and end bit in the CRC
    localparam sd_spi_pkg::sd_cmd_t EXP_CMD0   = '{8'h40, 32'h0000_0000, 8'h95};
    localparam sd_spi_pkg::sd_cmd_t EXP_CMD8   = '{8'h48, 32'h0000_01AA, 8'h87};
    localparam sd_spi_pkg::sd_cmd_t EXP_CMD55  = '{8'h77, 32'h0000_0000, 8'h01};
    localparam sd_spi_pkg::sd_cmd_t EXP_ACMD41 = '{8'h69, 32'h4000_0000, 8'h01};
    localparam sd_spi_pkg::sd_cmd_t EXP_CMD58  = '{8'h7A, 32'h0000_0000, 8'h01};
    localparam sd_spi_pkg::sd_cmd_t EXP_CMD59  = '{8'h7B, 32'h0000_0000, 8'h91};
    localparam sd_spi_pkg::sd_cmd_t NO_CMD     = '0;

    typedef struct packed {
        sd_spi_pkg::cmd_op_e op;       // Expected kind of operation
        logic [31:0]         addr;
        logic                we;
        logic [31:0]         wdata;
        sd_spi_pkg::sd_cmd_t cmd_a;
        sd_spi_pkg::sd_cmd_t cmd_b;    // ACMD41 after CMD55
        logic [7:0]          r1;
        logic [7:0]          mid;      // Second R1 or start token
        logic [31:0]         tail;
        logic [31:0]         exp_rdata;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    sd_spi_pkg::bus_req_t bus_req;
    sd_spi_pkg::bus_rsp_t bus_rsp;
    logic                 miso = 1'b1;
    logic                 sclk;
    logic                 mosi;
    logic                 cs_n;

    row_t                 rows [0:NUM_ROWS-1];
    int                   seed = 32'h5c221323;
    int                   cycle = 0;
    int                   limit = 0;
    int                   row_id = 0;
    int                   loaded_id = 0;
    int                   sclk_rises = 0;
    int                   cs_rises = 0;
    int                   idle_rises = 0;   // Rises with cs_n and MOSI high
    int                   rise_cycle = 0;
    int                   high_cycles = 0;
    logic                 sclk_prev = 1'b0;
    logic [STREAM_W-1:0]  card_stream = '1;
    logic [STREAM_W-1:0]  card_shift = '1;
    logic [STREAM_W-1:0]  mosi_log = '1;

    sd_spi_host dut0 (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .miso_i    (miso),
        .sclk_o    (sclk),
        .mosi_o    (mosi),
        .cs_n_o    (cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cmd(input string name, input sd_spi_pkg::sd_cmd_t got,
                             input sd_spi_pkg::sd_cmd_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // SCLK pulses under cs_n low for one operation
    function automatic int row_bits(input sd_spi_pkg::cmd_op_e op);
        case (op)
            sd_spi_pkg::OP_INIT:   return 128;
            sd_spi_pkg::OP_CMD0,
            sd_spi_pkg::OP_CMD59:  return 72;
            sd_spi_pkg::OP_CMD8,
            sd_spi_pkg::OP_CMD58:  return 104;
            sd_spi_pkg::OP_ACMD41: return 144;
            sd_spi_pkg::OP_READ:   return 112;
            default:               return 0;
        endcase
    endfunction

    // Card answer, first bit at the MSB, 64 command bits come first
    function automatic logic [STREAM_W-1:0] build_stream(input row_t r);
        case (r.op)
            sd_spi_pkg::OP_CMD0, sd_spi_pkg::OP_CMD59:
                return {64'hFFFF_FFFF_FFFF_FFFF, r.r1, {88{1'b1}}};
            sd_spi_pkg::OP_CMD8, sd_spi_pkg::OP_CMD58:
                return {64'hFFFF_FFFF_FFFF_FFFF, r.r1, r.tail, {56{1'b1}}};
            sd_spi_pkg::OP_ACMD41:
                return {64'hFFFF_FFFF_FFFF_FFFF, r.r1, 64'hFFFF_FFFF_FFFF_FFFF, r.mid,
                        {16{1'b1}}};
            sd_spi_pkg::OP_READ:
                return {64'hFFFF_FFFF_FFFF_FFFF, r.r1, r.mid, r.tail, {48{1'b1}}};
            default:
                return '1;
        endcase
    endfunction

    task automatic build_table();
        logic [31:0] rd_addr;
        logic [31:0] rd_data;
        rd_addr = sd_spi_pkg::READ_BASE | (32'($random(seed)) & 32'h0FFF_FFFC);
        rd_data = 32'($random(seed));
        rows[0] = '{sd_spi_pkg::OP_BAUD, sd_spi_pkg::OFS_BAUD, 1'b1, 32'(DIV_TB),
                    NO_CMD, NO_CMD, 8'h00, 8'h00, 32'h0, 32'hFFFF_FFFF};
        rows[1] = '{sd_spi_pkg::OP_NONE, 32'h0000_0020, 1'b0, 32'h0,
                    NO_CMD, NO_CMD, 8'h00, 8'h00, 32'h0, 32'hFFFF_FFFF};
        rows[2] = '{sd_spi_pkg::OP_INIT, sd_spi_pkg::OFS_INIT, 1'b1, 32'h0,
                    NO_CMD, NO_CMD, 8'h00, 8'h00, 32'h0, 32'hFFFF_FFFF};
        rows[3] = '{sd_spi_pkg::OP_CMD0, sd_spi_pkg::OFS_CMD0, 1'b1, 32'h0,
                    EXP_CMD0, NO_CMD, 8'h01, 8'h00, 32'h0, 32'h0000_0001};
        rows[4] = '{sd_spi_pkg::OP_CMD8, sd_spi_pkg::OFS_CMD8, 1'b1, 32'h0,
                    EXP_CMD8, NO_CMD, 8'h01, 8'h00, 32'h0000_01AA, 32'h0000_01AA};
        rows[5] = '{sd_spi_pkg::OP_CMD59, sd_spi_pkg::OFS_CMD59, 1'b1, 32'h0,
                    EXP_CMD59, NO_CMD, 8'h05, 8'h00, 32'h0, 32'h0000_0005};
        rows[6] = '{sd_spi_pkg::OP_ACMD41, sd_spi_pkg::OFS_ACMD41, 1'b1, 32'h0,
                    EXP_CMD55, EXP_ACMD41, 8'h01, 8'h00, 32'h0, 32'h0000_0000};
        rows[7] = '{sd_spi_pkg::OP_CMD58, sd_spi_pkg::OFS_CMD58, 1'b0, 32'h0,
                    EXP_CMD58, NO_CMD, 8'h00, 8'h00, 32'hC0FF_8000, 32'hC0FF_8000};
        rows[8] = '{sd_spi_pkg::OP_READ, rd_addr, 1'b0, 32'h0,
                    '{8'h51, rd_addr >> 2, 8'h01}, NO_CMD, 8'h00, 8'hFE, rd_data, rd_data};
        // Write into the read window is a no-op
        rows[9] = '{sd_spi_pkg::OP_NONE, rd_addr, 1'b1, 32'h1234_5678,
                    NO_CMD, NO_CMD, 8'h00, 8'h00, 32'h0, 32'hFFFF_FFFF};
    endtask

    ////////////////////////////////////////
    // Card model and SCLK monitor
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (row_id != loaded_id) begin
            card_shift = card_stream;
            loaded_id  = row_id;
        end
        if (sclk && !sclk_prev) begin
            sclk_rises++;
            rise_cycle = cycle;
            if (!cs_n) begin
                cs_rises++;
                mosi_log   = {mosi_log[STREAM_W-2:0], mosi};
                card_shift = {card_shift[STREAM_W-2:0], 1'b1};
            end else if (mosi) begin
                idle_rises++;
            end
        end
        if (!sclk && sclk_prev) high_cycles = cycle - rise_cycle;
        sclk_prev = sclk;
        miso      = card_shift[STREAM_W-1];   // Next bit before the next rise
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    // Command window of 64 MOSI bits, ones around the 48-bit command
    task automatic check_cmd_window(input string name, input int shift,
                                    input sd_spi_pkg::sd_cmd_t exp);
        logic [63:0] win;
        win = 64'(mosi_log >> shift);
        check_word({name, "_pad"}, {16'h0000, win[63:56], win[7:0]}, 32'h0000_FFFF);
        check_cmd(name, win[55:8], exp);
    endtask

    task automatic run_row(input row_t r);
        int          lat;
        int          sclk0;
        int          cs0;
        int          idle0;
        int          n;
        logic [31:0] rdata;
        sclk0       = sclk_rises;
        cs0         = cs_rises;
        idle0       = idle_rises;
        n           = row_bits(r.op);
        card_stream = build_stream(r);
        row_id++;
        bus_req = '{req: 1'b1, we: r.we, addr: r.addr, wdata: r.wdata};
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!bus_rsp.gnt);
        rdata       = bus_rsp.rdata;
        bus_req.req = 1'b0;
        if (r.op == sd_spi_pkg::OP_INIT) begin
            check_count("sclk_pulses", sclk_rises - sclk0, 128);
            check_count("idle_mosi_pulses", idle_rises - idle0, 128);
            check_count("cs_low_pulses", cs_rises - cs0, 0);
        end else if (n > 0) begin
            check_count("cs_low_pulses", cs_rises - cs0, n);
            check_count("sclk_half_period", high_cycles, DIV_TB + 1);
            check_cmd_window("mosi_cmd", n - 64, r.cmd_a);
            if (r.op == sd_spi_pkg::OP_ACMD41) check_cmd_window("mosi_acmd41", n - 136, r.cmd_b);
        end else begin
            check_count("gnt_latency", lat, 2);
            check_count("sclk_pulses", sclk_rises - sclk0, 0);
        end
        check_word("rdata", rdata, r.exp_rdata);
        @(negedge clk);                          // req low for a cycle
    endtask

    initial begin
        rst_n   = 1'b0;
        bus_req = '0;
        build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit += row_bits(rows[i].op) * 4 * (DIV_TB + 1);
        end
        limit += 200;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("cs_n", cs_n, 1'b1);
        check_bit("sclk", sclk, 1'b0);
        check_bit("gnt", bus_rsp.gnt, 1'b0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== test/sd_spi_host_assertions.sv ====
/*
 * SD SPI host protocol assertions
 * Grant pulse, chip select and SCLK rules, bound to the top level
 */
`timescale 1ns/1ps

module sd_spi_host_assertions (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                req_i,
    input logic                gnt_i,
    input logic                sclk_i,
    input logic                cs_n_i,
    input sd_spi_pkg::cmd_op_e op_i
);

    gnt_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        gnt_i |=> !gnt_i) else $error("gnt held longer than one cycle");

    // Requester may drop req in the grant cycle
    gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        gnt_i |-> $past(req_i)) else $error("gnt without a pending request");

    sclk_needs_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cs_n_i && op_i != sd_spi_pkg::OP_INIT) |-> !sclk_i)
        else $error("sclk toggles with chip select released");

    cs_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !req_i |-> cs_n_i) else $error("chip select low while the host is idle");

endmodule

bind sd_spi_host sd_spi_host_assertions u_assertions (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (bus_req_i.req),
    .gnt_i   (bus_rsp_o.gnt),
    .sclk_i  (sclk_o),
    .cs_n_i  (cs_n_o),
    .op_i    (op)
);

// ==== hdl/sd_spi_host.sv ====
/*
 * SD card host in SPI mode
 * Top level: bus front end, command sequencer and SPI shifter
 */
`timescale 1ns/1ps

module sd_spi_host (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  sd_spi_pkg::bus_req_t  bus_req_i,
    output sd_spi_pkg::bus_rsp_t  bus_rsp_o,
    input  logic                  miso_i,
    output logic                  sclk_o,
    output logic                  mosi_o,
    output logic                  cs_n_o
);

    sd_spi_pkg::cmd_op_e              op;
    logic [sd_spi_pkg::DATA_W-1:0]    arg;
    logic                             start;
    logic [sd_spi_pkg::DIV_W-1:0]     div;
    logic                             seq_done;
    logic [sd_spi_pkg::DATA_W-1:0]    result;
    sd_spi_pkg::spi_frame_t           frame;
    logic                             frame_valid;
    logic                             frame_done;
    logic [sd_spi_pkg::DATA_W-1:0]    rx_word;

    sd_spi_reg_front u_reg_front (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .bus_req_i  (bus_req_i),
        .seq_done_i (seq_done),
        .result_i   (result),
        .bus_rsp_o  (bus_rsp_o),
        .op_o       (op),
        .arg_o      (arg),
        .start_o    (start),
        .div_o      (div)
    );

    sd_spi_cmd_seq u_cmd_seq (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .op_i          (op),
        .arg_i         (arg),
        .start_i       (start),
        .frame_done_i  (frame_done),
        .rx_word_i     (rx_word),
        .frame_o       (frame),
        .frame_valid_o (frame_valid),
        .seq_done_o    (seq_done),
        .result_o      (result)
    );

    sd_spi_shifter u_shifter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .div_i         (div),
        .frame_i       (frame),
        .frame_valid_i (frame_valid),
        .miso_i        (miso_i),
        .frame_done_o  (frame_done),
        .rx_word_o     (rx_word),
        .sclk_o        (sclk_o),
        .mosi_o        (mosi_o),
        .cs_n_o        (cs_n_o)
    );

endmodule

// ==== hdl/sd_spi_shifter.sv ====
/*
 * SD SPI shifter
 * Mode 0 serializer with programmable SCLK divider and chip select
 * that stays low across back-to-back frames
 */
`timescale 1ns/1ps

module sd_spi_shifter (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [sd_spi_pkg::DIV_W-1:0]      div_i,
    input  sd_spi_pkg::spi_frame_t            frame_i,
    input  logic                              frame_valid_i,
    input  logic                              miso_i,
    output logic                              frame_done_o,
    output logic [sd_spi_pkg::DATA_W-1:0]     rx_word_o,
    output logic                              sclk_o,
    output logic                              mosi_o,
    output logic                              cs_n_o
);

    logic                             busy_q;
    logic                             sclk_q;
    logic                             done_q;
    logic                             cs_act_q;
    logic                             drive_q;
    logic [sd_spi_pkg::DIV_W-1:0]     half_cnt_q;
    logic [sd_spi_pkg::LEN_W-1:0]     bit_cnt_q;
    logic [sd_spi_pkg::DATA_W-1:0]    tx_q;
    logic [sd_spi_pkg::DATA_W-1:0]    rx_q;
    logic                             accept;
    logic                             tick;

    assign accept = frame_valid_i & ~busy_q;
    assign tick   = busy_q & (half_cnt_q == '0);   // End of a half period

    ////////////////////////////////////////
    // Clock and bit counting
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            sclk_q     <= 1'b0;
            done_q     <= 1'b0;
            cs_act_q   <= 1'b0;
            half_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy_q     <= 1'b1;
                half_cnt_q <= div_i;
                bit_cnt_q  <= frame_i.last;
                cs_act_q   <= ~frame_i.cs_high;
            end else if (busy_q) begin
                if (tick) begin
                    half_cnt_q <= div_i;
                    sclk_q     <= ~sclk_q;
                    if (sclk_q) begin                 // Falling edge
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                        if (bit_cnt_q == '0) begin
                            busy_q <= 1'b0;
                            done_q <= 1'b1;
                        end
                    end
                end else begin
                    half_cnt_q <= half_cnt_q - 1'b1;
                end
            end else if (!done_q) begin
                // No follow-up frame, release chip select
                cs_act_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (accept) begin
            tx_q    <= frame_i.data;
            rx_q    <= '0;              // Short frames come back zero-extended
            drive_q <= frame_i.drive;
        end else if (tick) begin
            if (sclk_q) tx_q <= {tx_q[sd_spi_pkg::DATA_W-2:0], 1'b1};
            else        rx_q <= {rx_q[sd_spi_pkg::DATA_W-2:0], miso_i};
        end
    end

    assign mosi_o       = (busy_q & drive_q) ? tx_q[sd_spi_pkg::DATA_W-1] : 1'b1;
    assign sclk_o       = sclk_q;
    assign cs_n_o       = ~cs_act_q;
    assign frame_done_o = done_q;
    assign rx_word_o    = rx_q;

endmodule

// ==== hdl/sd_spi_cmd_seq.sv ====
/*
 * SD SPI command sequencer
 * Walks the frame sequence of one operation and builds each
 * frame from the SD command table
 */
`timescale 1ns/1ps

module sd_spi_cmd_seq (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  sd_spi_pkg::cmd_op_e               op_i,
    input  logic [sd_spi_pkg::DATA_W-1:0]     arg_i,
    input  logic                              start_i,
    input  logic                              frame_done_i,
    input  logic [sd_spi_pkg::DATA_W-1:0]     rx_word_i,
    output sd_spi_pkg::spi_frame_t            frame_o,
    output logic                              frame_valid_o,
    output logic                              seq_done_o,
    output logic [sd_spi_pkg::DATA_W-1:0]     result_o
);

    typedef enum logic [2:0] {
        FR_CMD_HI,   // 0xFF, index, upper argument half
        FR_CMD_LO,   // Lower argument half, CRC, 0xFF
        FR_R8,
        FR_R32,
        FR_IDLE
    } frame_kind_e;

    sd_spi_pkg::cmd_op_e              op_q;
    logic [sd_spi_pkg::DATA_W-1:0]    arg_q;
    logic [sd_spi_pkg::DATA_W-1:0]    result_q;
    logic [sd_spi_pkg::STEP_W-1:0]    step_q;      // Frames left
    logic [sd_spi_pkg::STEP_W-1:0]    frame_cnt;
    logic                             send_q;
    logic                             done_q;
    sd_spi_pkg::sd_cmd_t              cmd;
    frame_kind_e                      kind;

    // Number of frames per operation
    always_comb begin
        case (op_i)
            sd_spi_pkg::OP_INIT:   frame_cnt = sd_spi_pkg::STEP_W'(sd_spi_pkg::INIT_FRAMES);
            sd_spi_pkg::OP_CMD8,
            sd_spi_pkg::OP_CMD58:  frame_cnt = 3'd4;
            sd_spi_pkg::OP_ACMD41: frame_cnt = 3'd6;
            sd_spi_pkg::OP_READ:   frame_cnt = 3'd5;
            default:               frame_cnt = 3'd3;   // CMD0, CMD59
        endcase
    end

    ////////////////////////////////////////
    // Step to frame kind
    ////////////////////////////////////////
    always_comb begin
        cmd  = sd_spi_pkg::SD_CMD0;
        kind = FR_IDLE;
        case (op_q)
            sd_spi_pkg::OP_CMD0, sd_spi_pkg::OP_CMD59: begin
                if (op_q == sd_spi_pkg::OP_CMD59) cmd = sd_spi_pkg::SD_CMD59;
                case (step_q)
                    3'd3:    kind = FR_CMD_HI;
                    3'd2:    kind = FR_CMD_LO;
                    default: kind = FR_R8;
                endcase
            end
            sd_spi_pkg::OP_CMD8, sd_spi_pkg::OP_CMD58: begin
                cmd = (op_q == sd_spi_pkg::OP_CMD8) ? sd_spi_pkg::SD_CMD8 : sd_spi_pkg::SD_CMD58;
                case (step_q)
                    3'd4:    kind = FR_CMD_HI;
                    3'd3:    kind = FR_CMD_LO;
                    3'd2:    kind = FR_R8;
                    default: kind = FR_R32;       // OCR or echo tail
                endcase
            end
            sd_spi_pkg::OP_ACMD41: begin
                // CMD55 first, then ACMD41
                cmd = (step_q > 3'd3) ? sd_spi_pkg::SD_CMD55 : sd_spi_pkg::SD_ACMD41;
                case (step_q)
                    3'd6, 3'd3: kind = FR_CMD_HI;
                    3'd5, 3'd2: kind = FR_CMD_LO;
                    default:    kind = FR_R8;
                endcase
            end
            sd_spi_pkg::OP_READ: begin
                cmd = '{idx: sd_spi_pkg::CMD17_IDX, arg: arg_q, crc: sd_spi_pkg::CMD17_CRC};
                case (step_q)
                    3'd5:    kind = FR_CMD_HI;
                    3'd4:    kind = FR_CMD_LO;
                    3'd1:    kind = FR_R32;       // First data word
                    default: kind = FR_R8;        // R1, then start token
                endcase
            end
            default: kind = FR_IDLE;
        endcase
    end

    always_comb begin
        frame_o.data    = sd_spi_pkg::IDLE_WORD;
        frame_o.last    = sd_spi_pkg::LAST_WORD;
        frame_o.drive   = 1'b0;
        frame_o.cs_high = 1'b0;
        case (kind)
            FR_CMD_HI: begin
                frame_o.data  = {8'hFF, cmd.idx, cmd.arg[31:16]};
                frame_o.drive = 1'b1;
            end
            FR_CMD_LO: begin
                frame_o.data  = {cmd.arg[15:0], cmd.crc, 8'hFF};
                frame_o.drive = 1'b1;
            end
            FR_R8:   frame_o.last = sd_spi_pkg::LAST_BYTE;
            FR_R32:  frame_o.last = sd_spi_pkg::LAST_WORD;
            default: frame_o.cs_high = 1'b1;     // Power-up clocks
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            op_q   <= sd_spi_pkg::OP_NONE;
            step_q <= '0;
            send_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            send_q <= 1'b0;        // Shifter is idle whenever a frame is offered
            done_q <= 1'b0;
            if (start_i) begin
                op_q   <= op_i;
                step_q <= frame_cnt;
                send_q <= 1'b1;
            end else if (frame_done_i) begin
                step_q <= step_q - 1'b1;
                if (step_q == 3'd1) done_q <= 1'b1;
                else                send_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i)      arg_q    <= arg_i;
        if (frame_done_i) result_q <= rx_word_i;
    end

    assign frame_valid_o = send_q;
    assign seq_done_o    = done_q;
    assign result_o      = result_q;

endmodule

// ==== hdl/sd_spi_reg_front.sv ====
/*
 * SD SPI host bus front end
 * Decodes the register offset into an operation, keeps the SPI
 * divider and answers the bus with a one-cycle grant
 */
`timescale 1ns/1ps

module sd_spi_reg_front (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  sd_spi_pkg::bus_req_t              bus_req_i,
    input  logic                              seq_done_i,
    input  logic [sd_spi_pkg::DATA_W-1:0]     result_i,
    output sd_spi_pkg::bus_rsp_t              bus_rsp_o,
    output sd_spi_pkg::cmd_op_e               op_o,
    output logic [sd_spi_pkg::DATA_W-1:0]     arg_o,
    output logic                              start_o,
    output logic [sd_spi_pkg::DIV_W-1:0]      div_o
);

    logic                            req_q;
    logic                            new_req;
    logic                            edge_q;
    logic                            frame_op;
    logic                            gnt_q;
    logic [sd_spi_pkg::DATA_W-1:0]   rdata_q;
    logic [sd_spi_pkg::DATA_W-1:0]   arg_q;
    logic [sd_spi_pkg::DIV_W-1:0]    div_q;
    sd_spi_pkg::cmd_op_e             op_d;
    sd_spi_pkg::cmd_op_e             op_q;

    assign new_req = bus_req_i.req & ~req_q;   // Rising edge only

    ////////////////////////////////////////
    // Offset decode
    ////////////////////////////////////////
    always_comb begin
        op_d = sd_spi_pkg::OP_NONE;
        case (bus_req_i.addr)
            sd_spi_pkg::OFS_INIT:   op_d = sd_spi_pkg::OP_INIT;
            sd_spi_pkg::OFS_CMD0:   op_d = sd_spi_pkg::OP_CMD0;
            sd_spi_pkg::OFS_CMD8:   op_d = sd_spi_pkg::OP_CMD8;
            sd_spi_pkg::OFS_CMD58:  op_d = sd_spi_pkg::OP_CMD58;
            sd_spi_pkg::OFS_CMD59:  op_d = sd_spi_pkg::OP_CMD59;
            sd_spi_pkg::OFS_ACMD41: op_d = sd_spi_pkg::OP_ACMD41;
            sd_spi_pkg::OFS_BAUD: begin
                if (bus_req_i.we) op_d = sd_spi_pkg::OP_BAUD;
            end
            default: begin
                // Writes into the read window fall through as no-ops
                if (!bus_req_i.we && bus_req_i.addr >= sd_spi_pkg::READ_BASE &&
                    bus_req_i.addr <= sd_spi_pkg::READ_LAST) begin
                    op_d = sd_spi_pkg::OP_READ;
                end
            end
        endcase
    end

    assign frame_op = (op_q != sd_spi_pkg::OP_NONE) && (op_q != sd_spi_pkg::OP_BAUD);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q  <= 1'b0;
            edge_q <= 1'b0;
            gnt_q  <= 1'b0;
            op_q   <= sd_spi_pkg::OP_NONE;
            div_q  <= sd_spi_pkg::DIV_RESET;
        end else begin
            req_q  <= bus_req_i.req;
            edge_q <= new_req;
            if (new_req) op_q <= op_d;
            if (edge_q && op_q == sd_spi_pkg::OP_BAUD) begin
                div_q <= bus_req_i.wdata[sd_spi_pkg::DIV_W-1:0];
            end
            // Register-only ops finish here, the rest wait for the sequencer
            gnt_q <= (edge_q & ~frame_op) | seq_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (new_req) arg_q <= {2'b00, bus_req_i.addr[sd_spi_pkg::ADDR_W-1:2]};
        rdata_q <= seq_done_i ? result_i : sd_spi_pkg::IDLE_WORD;
    end

    assign start_o         = edge_q & frame_op;
    assign op_o            = op_q;
    assign arg_o           = arg_q;
    assign div_o           = div_q;
    assign bus_rsp_o.gnt   = gnt_q;
    assign bus_rsp_o.rdata = rdata_q;

endmodule

// ==== hdl/sd_spi_pkg.sv ====
/*
 * SD card SPI host, shared definitions
 * Bus widths, register map, SD command table and the structs
 * for bus requests, bus responses and SPI frames
 */
package sd_spi_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int DIV_W  = 8;     // SPI half period divider
    localparam int LEN_W  = 6;     // Last bit index of a frame
    localparam int STEP_W = 3;     // Frame counter in the sequencer

    localparam logic [LEN_W-1:0] LAST_WORD = 6'd31;
    localparam logic [LEN_W-1:0] LAST_BYTE = 6'd7;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////
    localparam logic [ADDR_W-1:0] OFS_INIT   = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] OFS_CMD0   = 32'h0000_0004;
    localparam logic [ADDR_W-1:0] OFS_CMD8   = 32'h0000_0008;
    localparam logic [ADDR_W-1:0] OFS_CMD58  = 32'h0000_000C;
    localparam logic [ADDR_W-1:0] OFS_CMD59  = 32'h0000_0010;
    localparam logic [ADDR_W-1:0] OFS_ACMD41 = 32'h0000_0014;
    localparam logic [ADDR_W-1:0] OFS_BAUD   = 32'h0000_0018;

    localparam logic [ADDR_W-1:0] READ_BASE = 32'h1000_0000;
    localparam logic [ADDR_W-1:0] READ_LAST = 32'h1FFF_FFFC;

    localparam logic [DIV_W-1:0]  DIV_RESET   = 8'h19;
    localparam int                INIT_FRAMES = 4;
    localparam logic [DATA_W-1:0] IDLE_WORD   = 32'hFFFF_FFFF;

    // Decoded bus operation
    typedef enum logic [3:0] {
        OP_NONE,
        OP_INIT,
        OP_CMD0,
        OP_CMD8,
        OP_CMD58,
        OP_CMD59,
        OP_ACMD41,
        OP_BAUD,
        OP_READ
    } cmd_op_e;

    // One 48-bit SD command, start and end bits included
    typedef struct packed {
        logic [7:0]  idx;
        logic [31:0] arg;
        logic [7:0]  crc;
    } sd_cmd_t;

    localparam sd_cmd_t SD_CMD0   = '{idx: 8'h40, arg: 32'h0000_0000, crc: 8'h95};
    localparam sd_cmd_t SD_CMD8   = '{idx: 8'h48, arg: 32'h0000_01AA, crc: 8'h87};
    localparam sd_cmd_t SD_CMD55  = '{idx: 8'h77, arg: 32'h0000_0000, crc: 8'h01};
    localparam sd_cmd_t SD_ACMD41 = '{idx: 8'h69, arg: 32'h4000_0000, crc: 8'h01};
    localparam sd_cmd_t SD_CMD58  = '{idx: 8'h7A, arg: 32'h0000_0000, crc: 8'h01};
    localparam sd_cmd_t SD_CMD59  = '{idx: 8'h7B, arg: 32'h0000_0000, crc: 8'h91};
    localparam logic [7:0] CMD17_IDX = 8'h51;   // Argument filled in at run time
    localparam logic [7:0] CMD17_CRC = 8'h01;

    // One frame for the shifter, MSB of data goes out first
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [LEN_W-1:0]  last;
        logic              drive;     // Clear keeps MOSI high
        logic              cs_high;   // Clock with chip select released
    } spi_frame_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              gnt;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

endpackage
